// File: build.f
+incdir+hdl
hdl/fsync_msg_pkg.sv
hdl/fsync_node_pkg.sv
hdl/fsync_link_if.sv
hdl/fsync_node_1d.sv
hdl/fsync_node_2d.sv
hdl/fsync_2x2.sv
sim/fsync_tb.sv

// File: Makefile
# Verilator build and run of the 2x2 barrier network testbench
# Any variable can be overridden on the command line, e.g. make test BUILD_DIR=out

VERILATOR ?= verilator
TOP       ?= fsync_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/fsync_tb.sv
// Self-checking testbench for the 2x2 barrier network
// Rows run one at a time; a row ends when all of its CUs have woken
// The testbench plays the external parent and answers every external sync
// with a level 2 wake of the same id after EXT_GAP cycles
// Latencies are checked exactly, which holds because only one barrier is open

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_tb;
  import fsync_msg_pkg::*;

  localparam int N_CU       = `FSYNC_N_CU;
  localparam int N_DIRECTED = 7;
  localparam int N_RANDOM   = 12;
  localparam int N_ROWS     = N_DIRECTED + N_RANDOM;
  localparam int EXT_GAP    = 3;   // Parent answer delay
  localparam int ROW_LIMIT  = 40;  // Cycles before a row times out
  localparam int QUIET      = 8;   // Watch window for rows without wakes

  typedef struct packed {
    logic            dir;        // 0 horizontal, 1 vertical
    logic [N_CU-1:0] mask;       // CUs that sync
    fsync_in_aggr_t  aggr;
    fsync_id_t       id;
    fsync_lvl_t      lvl;        // Expected level
    int              dup_cu;     // Syncs twice before the others, -1 for none
    logic [N_CU-1:0] wake_mask;  // CUs that must wake
  } row_t;

  logic            clk_i;
  logic            rst_n_i;
  logic [N_CU-1:0] h_sync_i, v_sync_i;
  fsync_in_aggr_t  h_aggr_i[N_CU], v_aggr_i[N_CU];
  fsync_id_t       h_id_i[N_CU], v_id_i[N_CU];
  logic [N_CU-1:0] h_wake_o, v_wake_o, h_error_o, v_error_o;
  fsync_lvl_t      h_lvl_o[N_CU], v_lvl_o[N_CU];
  fsync_id_t       h_rsp_id_o[N_CU], v_rsp_id_o[N_CU];
  logic            h_2d_sync_o, v_2d_sync_o;
  fsync_out_aggr_t h_2d_aggr_o, v_2d_aggr_o;
  fsync_id_t       h_2d_id_o, v_2d_id_o;
  logic            h_2d_wake_i, v_2d_wake_i;
  fsync_lvl_t      h_2d_lvl_i, v_2d_lvl_i;
  fsync_id_t       h_2d_rsp_id_i, v_2d_rsp_id_i;

  row_t        rows[N_ROWS];
  logic [31:0] lcg_state;

  fsync_2x2 dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Error reporting and compares
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_error(input string msg);
    fail_run($sformatf("** Error at %0t: %s", $time, msg));
  endtask

  task automatic check_lvl(input string what, input fsync_lvl_t got, input fsync_lvl_t exp);
    if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_id(input string what, input fsync_id_t got, input fsync_id_t exp);
    if (got !== exp) report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
  endtask

  task automatic check_out_aggr(input string what, input fsync_out_aggr_t got,
                                input fsync_out_aggr_t exp);
    if (got !== exp) report_error($sformatf("%s is %0b, expected %0b", what, got, exp));
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row generation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Highest set bit of the mask is the barrier level
  function automatic fsync_lvl_t top_level(input fsync_in_aggr_t aggr);
    fsync_lvl_t lvl;
    lvl = '0;
    for (int b = 0; b < $bits(aggr); b++) begin
      if (aggr[b]) lvl = fsync_lvl_t'(b);
    end
    return lvl;
  endfunction

  function automatic row_t make_row(input logic dir, input logic [N_CU-1:0] mask,
                                    input fsync_in_aggr_t aggr, input fsync_id_t id,
                                    input fsync_lvl_t lvl, input int dup_cu,
                                    input logic [N_CU-1:0] wake_mask);
    row_t r;
    r.dir       = dir;
    r.mask      = mask;
    r.aggr      = aggr;
    r.id        = id;
    r.lvl       = lvl;
    r.dup_cu    = dup_cu;
    r.wake_mask = wake_mask;
    return r;
  endfunction

  function automatic row_t random_row();
    row_t        r;
    logic [31:0] rnd;
    rnd      = next_rand();
    r.dir    = rnd[31];
    r.aggr   = {rnd[30:29], 1'b1};  // CU always joins level 1
    r.id     = rnd[28:27];
    r.lvl    = top_level(r.aggr);
    r.dup_cu = -1;
    if (r.lvl != 0) r.mask = 4'b1111;
    else if (r.dir) r.mask = rnd[26] ? 4'b1010 : 4'b0101;  // Column pairs
    else r.mask = rnd[26] ? 4'b1100 : 4'b0011;             // Row pairs
    r.wake_mask = r.mask;
    return r;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Row execution
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic drive_sync(input row_t r, input int cu);
    if (r.dir) begin
      v_sync_i[cu] = 1'b1;
      v_aggr_i[cu] = r.aggr;
      v_id_i[cu]   = r.id;
    end else begin
      h_sync_i[cu] = 1'b1;
      h_aggr_i[cu] = r.aggr;
      h_id_i[cu]   = r.id;
    end
  endtask

  task automatic run_row(input int n, input row_t r);
    int              order[$];
    int              last;
    int              exp_wake;
    int              ext_at;
    int              j;
    int              tmp;
    logic [N_CU-1:0] woke;
    logic            done;
    logic            w;
    logic            e;
    logic            x_sync;
    fsync_id_t       x_id;
    for (int c = 0; c < N_CU; c++) begin
      if (r.mask[c] && c != r.dup_cu) order.push_back(c);
    end
    for (int i = order.size() - 1; i > 0; i--) begin
      j        = int'((next_rand() >> 16) % (i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    if (r.dup_cu >= 0) begin  // Same port twice, ahead of the partner
      order.push_front(r.dup_cu);
      order.push_front(r.dup_cu);
    end
    last     = order.size() - 1;
    exp_wake = r.lvl == 0 ? last + 1 : (r.lvl == 1 ? last + 3 : -1);
    ext_at   = -1;
    x_id     = '0;
    woke     = '0;
    done     = 1'b0;
    for (int t = 0; t < ROW_LIMIT && !done; t++) begin
      @(negedge clk_i);
      h_sync_i    = '0;
      v_sync_i    = '0;
      h_2d_wake_i = 1'b0;
      v_2d_wake_i = 1'b0;
      // CU side responses
      for (int c = 0; c < N_CU; c++) begin
        w = r.dir ? v_wake_o[c] : h_wake_o[c];
        e = r.dir ? v_error_o[c] : h_error_o[c];
        if ((r.dir ? (h_wake_o[c] | h_error_o[c]) : (v_wake_o[c] | v_error_o[c])) !== 1'b0)
          report_error($sformatf("row %0d CU%0d responded on the idle direction", n, c));
        if (e !== (r.dup_cu == c && t == 2))
          report_error($sformatf("row %0d CU%0d error strobe is %b at cycle %0d", n, c, e, t));
        if (e) check_id($sformatf("row %0d CU%0d error id", n, c),
                        r.dir ? v_rsp_id_o[c] : h_rsp_id_o[c], r.id);
        if (w) begin
          if (!r.wake_mask[c] || woke[c])
            report_error($sformatf("row %0d CU%0d woke unexpectedly", n, c));
          if (t != exp_wake)
            report_error($sformatf("row %0d CU%0d woke at cycle %0d, expected %0d",
                                   n, c, t, exp_wake));
          check_lvl($sformatf("row %0d CU%0d lvl", n, c), r.dir ? v_lvl_o[c] : h_lvl_o[c], r.lvl);
          check_id($sformatf("row %0d CU%0d id", n, c),
                   r.dir ? v_rsp_id_o[c] : h_rsp_id_o[c], r.id);
          woke[c] = 1'b1;
        end
      end
      // External parent
      x_sync = r.dir ? v_2d_sync_o : h_2d_sync_o;
      if ((r.dir ? h_2d_sync_o : v_2d_sync_o) || (x_sync && (r.lvl != 2 || t != last + 2)))
        report_error($sformatf("row %0d unexpected external sync at cycle %0d", n, t));
      if (x_sync) begin
        check_out_aggr($sformatf("row %0d external aggr", n),
                       r.dir ? v_2d_aggr_o : h_2d_aggr_o, fsync_out_aggr_t'(1));
        x_id = r.dir ? v_2d_id_o : h_2d_id_o;
        check_id($sformatf("row %0d external id", n), x_id, r.id);
        ext_at   = t + EXT_GAP;
        exp_wake = ext_at + 2;  // Back down through both node levels
      end
      // Drive this cycle's strobes
      if (t < order.size()) drive_sync(r, order[t]);
      if (t == ext_at) begin
        if (r.dir) begin
          v_2d_wake_i   = 1'b1;
          v_2d_lvl_i    = fsync_lvl_t'(2);
          v_2d_rsp_id_i = x_id;
        end else begin
          h_2d_wake_i   = 1'b1;
          h_2d_lvl_i    = fsync_lvl_t'(2);
          h_2d_rsp_id_i = x_id;
        end
      end
      done = (t > last) && (r.wake_mask != '0 ? woke == r.wake_mask : t >= last + QUIET);
    end
    if (!done) fail_run($sformatf("Timeout: row %0d got no complete set of wakes", n));
  endtask

  initial begin
    lcg_state     = 32'hd2c4f780;
    rst_n_i       = 1'b0;
    h_sync_i      = '0;
    v_sync_i      = '0;
    h_2d_wake_i   = 1'b0;
    v_2d_wake_i   = 1'b0;
    h_2d_lvl_i    = '0;
    v_2d_lvl_i    = '0;
    h_2d_rsp_id_i = '0;
    v_2d_rsp_id_i = '0;
    for (int c = 0; c < N_CU; c++) begin
      h_aggr_i[c] = '0;
      v_aggr_i[c] = '0;
      h_id_i[c]   = '0;
      v_id_i[c]   = '0;
    end

    // dir, CUs, aggr, id, lvl, dup CU, wakes
    rows[0] = make_row(1'b0, 4'b0011, 3'b001, 2'd1, 2'd0, -1, 4'b0011);  // Row pair
    rows[1] = make_row(1'b1, 4'b0101, 3'b001, 2'd0, 2'd0, -1, 4'b0101);  // Column pair
    rows[2] = make_row(1'b1, 4'b0010, 3'b001, 2'd1, 2'd0, -1, 4'b0000);  // CU1 alone
    rows[3] = make_row(1'b1, 4'b1000, 3'b001, 2'd1, 2'd0, -1, 4'b1010);  // CU3 completes it
    rows[4] = make_row(1'b0, 4'b1111, 3'b011, 2'd0, 2'd1, -1, 4'b1111);
    rows[5] = make_row(1'b1, 4'b1111, 3'b111, 2'd2, 2'd2, -1, 4'b1111);
    rows[6] = make_row(1'b0, 4'b0011, 3'b001, 2'd3, 2'd0, 0, 4'b0011);   // Duplicate id
    for (int i = N_DIRECTED; i < N_ROWS; i++) rows[i] = random_row();

    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;

    for (int i = 0; i < N_ROWS; i++) run_row(i, rows[i]);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: hdl/fsync_2x2.sv
// Barrier network for four CUs on a 2x2 grid
// CU c sits at row c/2, column c%2; the mapping below assumes that layout
// Horizontal pairs are CU0/CU1 and CU2/CU3, vertical pairs CU0/CU2 and CU1/CU3
// The external parent must answer every external sync with a wake of the same id

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_2x2 (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // CU horizontal ports
  input  logic [`FSYNC_N_CU-1:0]         h_sync_i,
  input  fsync_msg_pkg::fsync_in_aggr_t  h_aggr_i[`FSYNC_N_CU],
  input  fsync_msg_pkg::fsync_id_t       h_id_i[`FSYNC_N_CU],
  output logic [`FSYNC_N_CU-1:0]         h_wake_o,
  output logic [`FSYNC_N_CU-1:0]         h_error_o,
  output fsync_msg_pkg::fsync_lvl_t      h_lvl_o[`FSYNC_N_CU],
  output fsync_msg_pkg::fsync_id_t       h_rsp_id_o[`FSYNC_N_CU],
  // CU vertical ports
  input  logic [`FSYNC_N_CU-1:0]         v_sync_i,
  input  fsync_msg_pkg::fsync_in_aggr_t  v_aggr_i[`FSYNC_N_CU],
  input  fsync_msg_pkg::fsync_id_t       v_id_i[`FSYNC_N_CU],
  output logic [`FSYNC_N_CU-1:0]         v_wake_o,
  output logic [`FSYNC_N_CU-1:0]         v_error_o,
  output fsync_msg_pkg::fsync_lvl_t      v_lvl_o[`FSYNC_N_CU],
  output fsync_msg_pkg::fsync_id_t       v_rsp_id_o[`FSYNC_N_CU],
  // External parent
  output logic                           h_2d_sync_o,
  output logic                           v_2d_sync_o,
  output fsync_msg_pkg::fsync_out_aggr_t h_2d_aggr_o,
  output fsync_msg_pkg::fsync_out_aggr_t v_2d_aggr_o,
  output fsync_msg_pkg::fsync_id_t       h_2d_id_o,
  output fsync_msg_pkg::fsync_id_t       v_2d_id_o,
  input  logic                           h_2d_wake_i,
  input  logic                           v_2d_wake_i,
  input  fsync_msg_pkg::fsync_lvl_t      h_2d_lvl_i,
  input  fsync_msg_pkg::fsync_lvl_t      v_2d_lvl_i,
  input  fsync_msg_pkg::fsync_id_t       h_2d_rsp_id_i,
  input  fsync_msg_pkg::fsync_id_t       v_2d_rsp_id_i
);
  import fsync_msg_pkg::*;

  localparam int N_NODES = `FSYNC_N_1D_NODES;

  // Node side view, nodes 0-1 horizontal, 2-3 vertical
  logic [1:0]     n_sync[N_NODES];
  fsync_in_aggr_t n_aggr[N_NODES][2];
  fsync_id_t      n_id[N_NODES][2];
  logic [1:0]     n_wake[N_NODES];
  logic [1:0]     n_error[N_NODES];
  fsync_lvl_t     n_lvl[N_NODES][2];
  fsync_id_t      n_rsp_id[N_NODES][2];

  fsync_link_if h_link[2] ();
  fsync_link_if v_link[2] ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // CU to node port mapping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int c = 0; c < `FSYNC_N_CU; c++) begin
      // Horizontal, row pairs
      n_sync[c/2][c%2] = h_sync_i[c];
      n_aggr[c/2][c%2] = h_aggr_i[c];
      n_id[c/2][c%2]   = h_id_i[c];
      h_wake_o[c]      = n_wake[c/2][c%2];
      h_error_o[c]     = n_error[c/2][c%2];
      h_lvl_o[c]       = n_lvl[c/2][c%2];
      h_rsp_id_o[c]    = n_rsp_id[c/2][c%2];
      // Vertical, transposed into column pairs
      n_sync[2+c%2][c/2] = v_sync_i[c];
      n_aggr[2+c%2][c/2] = v_aggr_i[c];
      n_id[2+c%2][c/2]   = v_id_i[c];
      v_wake_o[c]        = n_wake[2+c%2][c/2];
      v_error_o[c]       = n_error[2+c%2][c/2];
      v_lvl_o[c]         = n_lvl[2+c%2][c/2];
      v_rsp_id_o[c]      = n_rsp_id[2+c%2][c/2];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Level-1 nodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar n = 0; n < N_NODES; n++) begin : gen_1d
    if (n < 2) begin : gen_h
      fsync_node_1d i_node (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sync_i   (n_sync[n]),
        .aggr_i   (n_aggr[n]),
        .id_i     (n_id[n]),
        .wake_o   (n_wake[n]),
        .error_o  (n_error[n]),
        .lvl_o    (n_lvl[n]),
        .rsp_id_o (n_rsp_id[n]),
        .up       (h_link[n])
      );
    end else begin : gen_v
      fsync_node_1d i_node (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .sync_i   (n_sync[n]),
        .aggr_i   (n_aggr[n]),
        .id_i     (n_id[n]),
        .wake_o   (n_wake[n]),
        .error_o  (n_error[n]),
        .lvl_o    (n_lvl[n]),
        .rsp_id_o (n_rsp_id[n]),
        .up       (v_link[n-2])
      );
    end
  end

  // Level-2 node
  fsync_node_2d i_node_2d (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .h_in       (h_link),
    .v_in       (v_link),
    .h_sync_o   (h_2d_sync_o),
    .v_sync_o   (v_2d_sync_o),
    .h_aggr_o   (h_2d_aggr_o),
    .v_aggr_o   (v_2d_aggr_o),
    .h_id_o     (h_2d_id_o),
    .v_id_o     (v_2d_id_o),
    .h_wake_i   (h_2d_wake_i),
    .v_wake_i   (v_2d_wake_i),
    .h_lvl_i    (h_2d_lvl_i),
    .v_lvl_i    (v_2d_lvl_i),
    .h_rsp_id_i (h_2d_rsp_id_i),
    .v_rsp_id_i (v_2d_rsp_id_i)
  );

endmodule

// File: hdl/fsync_node_2d.sv
// Level-2 barrier node with one table per direction
// Index 0 of each table side is horizontal, index 1 vertical
// Inputs are completed level-1 barriers, so a repeated id is simply dropped
// External wakes are taken only for ids that were forwarded

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_node_2d (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  fsync_link_if.parent                  h_in[2],
  fsync_link_if.parent                  v_in[2],
  output logic                          h_sync_o,
  output logic                          v_sync_o,
  output fsync_msg_pkg::fsync_out_aggr_t h_aggr_o,
  output fsync_msg_pkg::fsync_out_aggr_t v_aggr_o,
  output fsync_msg_pkg::fsync_id_t      h_id_o,
  output fsync_msg_pkg::fsync_id_t      v_id_o,
  input  logic                          h_wake_i,
  input  logic                          v_wake_i,
  input  fsync_msg_pkg::fsync_lvl_t     h_lvl_i,
  input  fsync_msg_pkg::fsync_lvl_t     v_lvl_i,
  input  fsync_msg_pkg::fsync_id_t      h_rsp_id_i,
  input  fsync_msg_pkg::fsync_id_t      v_rsp_id_i
);
  import fsync_msg_pkg::*;
  import fsync_node_pkg::*;

  localparam int N_ID = 1 << `FSYNC_ID_WIDTH;

  // Per table side, then per link
  wire logic [1:0]      in_sync[2];
  wire fsync_itl_aggr_t in_aggr[2][2];
  wire fsync_id_t       in_id[2][2];
  wire logic            dn_wake[2];
  wire fsync_lvl_t      dn_lvl[2];
  wire fsync_id_t       dn_id[2];
  wire logic            ext_sync[2];
  wire fsync_out_aggr_t ext_aggr[2];
  wire fsync_id_t       ext_id[2];

  logic       ext_wake[2];
  fsync_lvl_t ext_lvl[2];
  fsync_id_t  ext_rsp_id[2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Link and port mapping
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar j = 0; j < 2; j++) begin : gen_links
    assign in_sync[0][j] = h_in[j].sync;
    assign in_aggr[0][j] = h_in[j].aggr;
    assign in_id[0][j]   = h_in[j].req_id;
    assign in_sync[1][j] = v_in[j].sync;
    assign in_aggr[1][j] = v_in[j].aggr;
    assign in_id[1][j]   = v_in[j].req_id;
    assign h_in[j].wake   = dn_wake[0];
    assign h_in[j].lvl    = dn_lvl[0];
    assign h_in[j].rsp_id = dn_id[0];
    assign v_in[j].wake   = dn_wake[1];
    assign v_in[j].lvl    = dn_lvl[1];
    assign v_in[j].rsp_id = dn_id[1];
  end

  assign ext_wake   = '{h_wake_i, v_wake_i};
  assign ext_lvl    = '{h_lvl_i, v_lvl_i};
  assign ext_rsp_id = '{h_rsp_id_i, v_rsp_id_i};

  assign h_sync_o = ext_sync[0];
  assign h_aggr_o = ext_aggr[0];
  assign h_id_o   = ext_id[0];
  assign v_sync_o = ext_sync[1];
  assign v_aggr_o = ext_aggr[1];
  assign v_id_o   = ext_id[1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Barrier tables
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  for (genvar g = 0; g < 2; g++) begin : gen_tbl
    entry_state_e    state_q[N_ID], state_d[N_ID];
    node_port_t      port_q[N_ID], port_d[N_ID];
    fsync_itl_aggr_t aggr_q[N_ID], aggr_d[N_ID];
    fsync_lvl_t      lvl_q[N_ID], lvl_d[N_ID];
    logic            wake_d, wake_q, fwd_d, fwd_q;
    fsync_id_t       wake_sel, fwd_sel, wake_id_q, fwd_id_q;
    fsync_lvl_t      wake_lvl_q;
    fsync_out_aggr_t fwd_aggr_q;

    always_comb begin
      logic            hit[2];
      logic            done;
      fsync_itl_aggr_t done_aggr;
      state_d  = state_q;
      port_d   = port_q;
      aggr_d   = aggr_q;
      lvl_d    = lvl_q;
      wake_d   = 1'b0;
      fwd_d    = 1'b0;
      wake_sel = '0;
      fwd_sel  = '0;
      for (int e = 0; e < N_ID; e++) begin
        done      = 1'b0;
        done_aggr = aggr_q[e];
        for (int j = 0; j < 2; j++) begin
          hit[j] = in_sync[g][j] && (in_id[g][j] == fsync_id_t'(e));
        end
        if (state_q[e] == IDLE && hit[0] && hit[1]) begin
          done      = 1'b1;
          done_aggr = in_aggr[g][0];
        end else if (state_q[e] == IDLE && (hit[0] || hit[1])) begin
          state_d[e] = HALF;
          port_d[e]  = node_port_t'(hit[1]);
          aggr_d[e]  = hit[1] ? in_aggr[g][1] : in_aggr[g][0];
        end else if (state_q[e] == HALF) begin
          done = port_q[e] ? hit[0] : hit[1]; // Other link arrived
        end
        if (done) begin
          aggr_d[e]  = done_aggr;
          lvl_d[e]   = fsync_lvl_t'(1);
          state_d[e] = (done_aggr >> 1) == '0 ? WAKE_PEND : FWD_PEND;
        end
        if (ext_wake[g] && ext_rsp_id[g] == fsync_id_t'(e) && state_q[e] == WAIT_UP) begin
          state_d[e] = WAKE_PEND;
          lvl_d[e]   = ext_lvl[g];
        end
      end
      for (int e = N_ID - 1; e >= 0; e--) begin
        if (state_d[e] == WAKE_PEND) begin
          wake_d   = 1'b1;
          wake_sel = fsync_id_t'(e);
        end
        if (state_d[e] == FWD_PEND) begin
          fwd_d   = 1'b1;
          fwd_sel = fsync_id_t'(e);
        end
      end
      if (wake_d) state_d[wake_sel] = IDLE;
      if (fwd_d) state_d[fwd_sel] = WAIT_UP;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        for (int e = 0; e < N_ID; e++) state_q[e] <= IDLE;
        wake_q <= 1'b0;
        fwd_q  <= 1'b0;
      end else begin
        state_q <= state_d;
        wake_q  <= wake_d;
        fwd_q   <= fwd_d;
      end
    end

    always_ff @(posedge clk_i) begin
      port_q     <= port_d;
      aggr_q     <= aggr_d;
      lvl_q      <= lvl_d;
      wake_id_q  <= wake_sel;
      wake_lvl_q <= lvl_d[wake_sel];
      fwd_id_q   <= fwd_sel;
      fwd_aggr_q <= fsync_out_aggr_t'(aggr_d[fwd_sel] >> 1); // Drop level 2 bit
    end

    assign dn_wake[g]  = wake_q;
    assign dn_lvl[g]   = wake_lvl_q;
    assign dn_id[g]    = wake_id_q;
    assign ext_sync[g] = fwd_q;
    assign ext_aggr[g] = fwd_aggr_q;
    assign ext_id[g]   = fwd_id_q;
  end

endmodule

// File: hdl/fsync_node_1d.sv
// Level-1 barrier node joining two CU ports
// One table entry per id; the first arrival's aggr sets the barrier level
// At most one wake and one forward per cycle, lowest id first
// Any error strobe this cycle holds back the wake by one cycle

`timescale 1ns/1ps

`include "fsync_settings.svh"

module fsync_node_1d (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [1:0]                  sync_i,
  input  fsync_msg_pkg::fsync_in_aggr_t aggr_i[2],
  input  fsync_msg_pkg::fsync_id_t    id_i[2],
  output logic [1:0]                  wake_o,
  output logic [1:0]                  error_o,
  output fsync_msg_pkg::fsync_lvl_t   lvl_o[2],
  output fsync_msg_pkg::fsync_id_t    rsp_id_o[2],
  fsync_link_if.child                 up
);
  import fsync_msg_pkg::*;
  import fsync_node_pkg::*;

  localparam int N_ID = 1 << `FSYNC_ID_WIDTH;

  entry_state_e   state_q[N_ID], state_d[N_ID];
  node_port_t     port_q[N_ID], port_d[N_ID];
  fsync_in_aggr_t aggr_q[N_ID], aggr_d[N_ID];
  fsync_lvl_t     lvl_q[N_ID], lvl_d[N_ID];

  logic            wake_d, wake_q;
  logic [1:0]      err_d, err_q;
  logic            fwd_d, fwd_q;
  fsync_id_t       wake_sel, fwd_sel;
  fsync_id_t       wake_id_q, fwd_id_q;
  fsync_id_t       err_id_q[2];
  fsync_lvl_t      wake_lvl_q;
  fsync_itl_aggr_t fwd_aggr_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Table update and arbitration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    logic           hit[2];
    logic           done;
    fsync_in_aggr_t done_aggr;
    state_d  = state_q;
    port_d   = port_q;
    aggr_d   = aggr_q;
    lvl_d    = lvl_q;
    err_d    = '0;
    wake_d   = 1'b0;
    fwd_d    = 1'b0;
    wake_sel = '0;
    fwd_sel  = '0;
    for (int e = 0; e < N_ID; e++) begin
      done      = 1'b0;
      done_aggr = aggr_q[e];
      for (int p = 0; p < 2; p++) begin
        hit[p] = sync_i[p] && (id_i[p] == fsync_id_t'(e));
      end
      case (state_q[e])
        IDLE: begin
          if (hit[0] && hit[1]) begin // Both sides at once
            done      = 1'b1;
            done_aggr = aggr_i[0];
          end else if (hit[0] || hit[1]) begin
            state_d[e] = HALF;
            port_d[e]  = node_port_t'(hit[1]);
            aggr_d[e]  = hit[1] ? aggr_i[1] : aggr_i[0];
          end
        end
        HALF: begin
          for (int p = 0; p < 2; p++) begin
            if (hit[p] && node_port_t'(p) == port_q[e]) err_d[p] = 1'b1; // Same side again
            else if (hit[p]) done = 1'b1;
          end
        end
        default: begin
          // Entry busy with an earlier barrier
          for (int p = 0; p < 2; p++) begin
            if (hit[p]) err_d[p] = 1'b1;
          end
        end
      endcase
      if (done) begin
        aggr_d[e]  = done_aggr;
        lvl_d[e]   = '0;
        state_d[e] = (done_aggr >> 1) == '0 ? WAKE_PEND : FWD_PEND;
      end
      if (up.wake && up.rsp_id == fsync_id_t'(e) && state_q[e] == WAIT_UP) begin
        state_d[e] = WAKE_PEND;
        lvl_d[e]   = up.lvl;
      end
    end

    // Descending scan, so the lowest id wins
    for (int e = N_ID - 1; e >= 0; e--) begin
      if (state_d[e] == WAKE_PEND) begin
        wake_d   = 1'b1;
        wake_sel = fsync_id_t'(e);
      end
      if (state_d[e] == FWD_PEND) begin
        fwd_d   = 1'b1;
        fwd_sel = fsync_id_t'(e);
      end
    end
    if (err_d != '0) wake_d = 1'b0;   // Errors go first
    if (wake_d) state_d[wake_sel] = IDLE;
    if (fwd_d) state_d[fwd_sel] = WAIT_UP;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int e = 0; e < N_ID; e++) state_q[e] <= IDLE;
      wake_q <= 1'b0;
      err_q  <= '0;
      fwd_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      wake_q  <= wake_d;
      err_q   <= err_d;
      fwd_q   <= fwd_d;
    end
  end

  // Payload, only meaningful alongside the strobes
  always_ff @(posedge clk_i) begin
    port_q     <= port_d;
    aggr_q     <= aggr_d;
    lvl_q      <= lvl_d;
    wake_id_q  <= wake_sel;
    wake_lvl_q <= lvl_d[wake_sel];
    fwd_id_q   <= fwd_sel;
    fwd_aggr_q <= fsync_itl_aggr_t'(aggr_d[fwd_sel] >> 1);
    err_id_q   <= id_i;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int p = 0; p < 2; p++) begin
      wake_o[p]   = wake_q;
      error_o[p]  = err_q[p];
      lvl_o[p]    = wake_lvl_q;
      rsp_id_o[p] = err_q[p] ? err_id_q[p] : wake_id_q;
    end
  end

  assign up.sync   = fwd_q;
  assign up.aggr   = fwd_aggr_q;
  assign up.req_id = fwd_id_q;

endmodule

// File: hdl/fsync_link_if.sv
// Link between a level-1 node and the level-2 node
// Strobes only, no ready; fields are valid only while their strobe is high

`timescale 1ns/1ps

interface fsync_link_if;
  import fsync_msg_pkg::*;

  // Upward request
  logic            sync;
  fsync_itl_aggr_t aggr;
  fsync_id_t       req_id;

  // Downward wake
  logic            wake;
  fsync_lvl_t      lvl;
  fsync_id_t       rsp_id;

  modport child (
    output sync, aggr, req_id,
    input  wake, lvl, rsp_id
  );

  modport parent (
    input  sync, aggr, req_id,
    output wake, lvl, rsp_id
  );

endinterface

// File: hdl/fsync_node_pkg.sv
// Types shared by the barrier nodes

package fsync_node_pkg;

  // Life of one barrier table entry
  typedef enum logic [2:0] {
    IDLE,      // No barrier open for this id
    HALF,      // One side arrived
    FWD_PEND,  // Completed, forward not yet sent
    WAIT_UP,   // Forwarded, waiting for the parent wake
    WAKE_PEND  // Wake ready, waiting for its turn
  } entry_state_e;

  // Which of the two node inputs
  typedef logic node_port_t;

endpackage

// File: hdl/fsync_msg_pkg.sv
// Field types of barrier requests and responses
// The aggr mask loses one bit at every level it climbs

`include "fsync_settings.svh"

package fsync_msg_pkg;

  // Barrier id
  typedef logic [`FSYNC_ID_WIDTH-1:0] fsync_id_t;

  // Level mask as sent by a CU
  typedef logic [`FSYNC_N_LEVELS-1:0] fsync_in_aggr_t;

  // Level mask from level-1 to level-2 nodes
  typedef logic [`FSYNC_N_LEVELS-2:0] fsync_itl_aggr_t;

  // Level mask toward the external parent
  typedef logic [`FSYNC_N_LEVELS-3:0] fsync_out_aggr_t;

  // Level at which a barrier ended, 0 to 2
  typedef logic [$clog2(`FSYNC_N_LEVELS)-1:0] fsync_lvl_t;

endpackage

// File: hdl/fsync_settings.svh
// Network sizes for the 2x2 barrier network
// The RTL assumes exactly four CUs on a 2x2 grid; other values are not supported
// Levels count the two on-chip levels plus the external one

`ifndef FSYNC_SETTINGS_SVH
`define FSYNC_SETTINGS_SVH

// Number of compute units
`define FSYNC_N_CU 4

// Width of the barrier id, one table entry per id value
`define FSYNC_ID_WIDTH 2

// Barrier levels, external level included
`define FSYNC_N_LEVELS 3

// Level-1 nodes, two horizontal and two vertical
`define FSYNC_N_1D_NODES 4

`endif
